// File: logic/cart_mapper_params.svh
`ifndef CART_MAPPER_PARAMS_SVH
`define CART_MAPPER_PARAMS_SVH

// SDRAM byte address width, 8 MB
`define CM_SDRAM_AW 23

// Widths of the translated offsets out of the banking block
`define CM_PRG_OFF_W 19
`define CM_CHR_OFF_W 15

// Supported PRG ROM sizes, log2 of bytes (32 KB to 512 KB)
`define CM_PRG_SIZE_MIN 5'd15
`define CM_PRG_SIZE_MAX 5'd19

// Fixed regions at the top of SDRAM
`define CM_LAUNCHER_CHR_BASE 23'h7D0000
`define CM_LAUNCHER_BASE 23'h7D8000
`define CM_WRAM_BASE 23'h7E0000

`endif

// File: logic/cart_mapper_pkg.sv
`default_nettype none

package cart_mapper_pkg;

    // Mapper kinds, as written to REG_MAPPER[1:0]
    typedef enum logic [1:0] {
        MAP_LAUNCHER = 2'd0,
        MAP_NROM     = 2'd1,
        MAP_UXROM    = 2'd2,
        MAP_CNROM    = 2'd3
    } mapper_kind_e;

    // APB addresses of the config registers
    typedef enum logic [3:0] {
        REG_MAPPER   = 4'h0,
        REG_LAUNCHER = 4'h4,
        REG_STATUS   = 4'h8
    } cfg_reg_e;

    // SDRAM region hit by a CPU access
    typedef enum logic [1:0] {
        SEL_NONE     = 2'd0,
        SEL_ROM      = 2'd1,
        SEL_WRAM     = 2'd2,
        SEL_LAUNCHER = 2'd3
    } prg_sel_e;

endpackage

`default_nettype wire

// File: logic/mapper_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_mapper_params.svh"

module mapper_cfg_regs (
    input  wire                           clk,
    input  wire                           cpu_reset,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire  [3:0]                    paddr,
    input  wire  [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire cart_mapper_pkg::mapper_kind_e active_kind,
    input  wire                           app_taken,
    input  wire                           menu_taken,
    output cart_mapper_pkg::mapper_kind_e pending_kind,
    output logic [4:0]                    prg_size,
    output logic                          mirroring,
    output logic                          load_app,
    output logic                          load_menu
);
    import cart_mapper_pkg::*;

    logic       apb_access;
    logic       addr_hit;
    logic       wr_mapper;
    logic       wr_menu;
    logic [4:0] size_wr;

    // Access phase of a transfer
    assign apb_access = psel && penable;

    assign addr_hit = (paddr == REG_MAPPER) || (paddr == REG_LAUNCHER)
                   || (paddr == REG_STATUS);

    assign wr_mapper = apb_access && pwrite && (paddr == REG_MAPPER);
    assign wr_menu = apb_access && pwrite && (paddr == REG_LAUNCHER) && pwdata[0];

    // No wait states
    assign pready = 1'b1;
    assign pslverr = apb_access && !addr_hit;

    // Clamp the PRG size into the supported range
    always_comb begin
        if (pwdata[6:2] < `CM_PRG_SIZE_MIN) begin
            size_wr = `CM_PRG_SIZE_MIN;
        end else if (pwdata[6:2] > `CM_PRG_SIZE_MAX) begin
            size_wr = `CM_PRG_SIZE_MAX;
        end else begin
            size_wr = pwdata[6:2];
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            pending_kind <= MAP_LAUNCHER;
            prg_size     <= `CM_PRG_SIZE_MIN;
            mirroring    <= 1'b0;
            load_app     <= 1'b0;
            load_menu    <= 1'b0;
        end else begin
            if (wr_mapper) begin
                pending_kind <= mapper_kind_e'(pwdata[1:0]);
                prg_size     <= size_wr;
                mirroring    <= pwdata[7];
            end else if (wr_menu) begin
                // Menu request always targets the launcher
                pending_kind <= MAP_LAUNCHER;
            end

            // New request beats the clear from the switch
            if (wr_mapper) begin
                load_app <= 1'b1;
            end else if (app_taken) begin
                load_app <= 1'b0;
            end

            if (wr_menu) begin
                load_menu <= 1'b1;
            end else if (menu_taken) begin
                load_menu <= 1'b0;
            end
        end
    end

    // Readback, same bit layout as the writes
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_MAPPER:   prdata[7:0] = {mirroring, prg_size, pending_kind};
            REG_LAUNCHER: prdata[0] = load_menu;
            REG_STATUS:   prdata[3:0] = {load_menu, load_app, active_kind};
            default:      prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mapper_switch.sv
`timescale 1ns/100ps
`default_nettype none

module mapper_switch (
    input  wire                           clk,
    input  wire                           cpu_reset,
    input  wire                           cpu_valid,
    input  wire                           cpu_rw,
    input  wire  [15:0]                   cpu_addr,
    input  wire cart_mapper_pkg::mapper_kind_e pending_kind,
    input  wire                           load_app,
    input  wire                           load_menu,
    output cart_mapper_pkg::mapper_kind_e active_kind,
    output cart_mapper_pkg::mapper_kind_e cur_kind,
    output logic                          bank_reset,
    output logic                          app_taken,
    output logic                          menu_taken
);
    import cart_mapper_pkg::*;

    logic         vector_read;
    logic         reset_hijack;
    logic         nmi_hijack;
    logic         hijack;
    mapper_kind_e target_kind;

    assign vector_read = cpu_valid && cpu_rw;

    // Reset vector fetch starts the loaded app
    assign reset_hijack = vector_read && (cpu_addr == 16'hFFFC) && load_app;

    // NMI vector fetch drops back into the menu
    assign nmi_hijack = vector_read && (cpu_addr == 16'hFFFA) && load_menu;

    assign hijack = reset_hijack || nmi_hijack;

    assign target_kind = nmi_hijack ? MAP_LAUNCHER : pending_kind;

    // The vector fetch itself is already served by the new mapper
    assign cur_kind = hijack ? target_kind : active_kind;

    // Flags in the register block clear on the same edge as the switch
    assign app_taken = reset_hijack;
    assign menu_taken = nmi_hijack;

    // Banks start from zero under a new mapper
    assign bank_reset = hijack && (target_kind != active_kind);

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            active_kind <= MAP_LAUNCHER;
        end else if (hijack) begin
            active_kind <= target_kind;
        end
    end

endmodule

`default_nettype wire

// File: logic/mapper_banking.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_mapper_params.svh"

module mapper_banking (
    input  wire                          clk,
    input  wire                          cpu_reset,
    input  wire                          bank_reset,
    input  wire cart_mapper_pkg::mapper_kind_e cur_kind,
    input  wire                          mirroring,
    input  wire                          cpu_valid,
    input  wire                          cpu_rw,
    input  wire  [15:0]                  cpu_addr,
    input  wire  [7:0]                   cpu_wdata,
    input  wire  [13:0]                  ppu_addr,
    output logic [`CM_PRG_OFF_W-1:0]     prg_off,
    output cart_mapper_pkg::prg_sel_e    prg_sel,
    output logic [`CM_CHR_OFF_W-1:0]     chr_off,
    output logic                         ciram_a10
);
    import cart_mapper_pkg::*;

    logic [2:0] prg_bank;
    logic [1:0] chr_bank;
    logic       bank_wr;
    logic [2:0] uxrom_bank;

    // Bank registers are mapped over the whole ROM window
    assign bank_wr = cpu_valid && !cpu_rw && cpu_addr[15];

    always_ff @(posedge clk) begin
        if (cpu_reset || bank_reset) begin
            prg_bank <= '0;
            chr_bank <= '0;
        end else if (bank_wr) begin
            if (cur_kind == MAP_UXROM) begin
                prg_bank <= cpu_wdata[2:0];
            end
            if (cur_kind == MAP_CNROM) begin
                chr_bank <= cpu_wdata[1:0];
            end
        end
    end

    // UxROM: switchable 16 KB at 8000, last bank fixed at C000
    assign uxrom_bank = cpu_addr[14] ? 3'd7 : prg_bank;

    always_comb begin
        prg_sel = SEL_NONE;
        prg_off = {6'd0, cpu_addr[12:0]};
        if (cpu_addr[15]) begin
            if (cur_kind == MAP_LAUNCHER) begin
                prg_sel = SEL_LAUNCHER;
            end else begin
                prg_sel = SEL_ROM;
            end
            if (cur_kind == MAP_UXROM) begin
                prg_off = {2'd0, uxrom_bank, cpu_addr[13:0]};
            end else begin
                prg_off = {4'd0, cpu_addr[14:0]};
            end
        end else if (cpu_addr[14:13] == 2'b11) begin
            // 6000-7FFF, work RAM
            prg_sel = SEL_WRAM;
        end
    end

    // CNROM switches the whole 8 KB pattern space
    always_comb begin
        if (cur_kind == MAP_CNROM) begin
            chr_off = {chr_bank, ppu_addr[12:0]};
        end else begin
            chr_off = {2'd0, ppu_addr[12:0]};
        end
    end

    // Vertical mirroring picks A10, horizontal picks A11
    assign ciram_a10 = mirroring ? ppu_addr[10] : ppu_addr[11];

endmodule

`default_nettype wire

// File: logic/sdram_addr_map.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_mapper_params.svh"

module sdram_addr_map (
    input  wire                          clk,
    input  wire                          cpu_reset,
    input  wire                          cpu_valid,
    input  wire                          cpu_rw,
    input  wire                          ppu_valid,
    input  wire                          ppu_rw,
    input  wire cart_mapper_pkg::mapper_kind_e cur_kind,
    input  wire  [4:0]                   prg_size,
    input  wire  [`CM_PRG_OFF_W-1:0]     prg_off,
    input  wire cart_mapper_pkg::prg_sel_e prg_sel,
    input  wire  [`CM_CHR_OFF_W-1:0]     chr_off,
    input  wire                          ciram_a10,
    output logic                         prg_req,
    output logic                         prg_we,
    output logic [`CM_SDRAM_AW-1:0]      prg_addr,
    output logic                         chr_req,
    output logic                         chr_we,
    output logic [`CM_SDRAM_AW-1:0]      chr_addr,
    output logic                         ciram_a10_q
);
    import cart_mapper_pkg::*;

    logic [`CM_SDRAM_AW-1:0] rom_size;
    logic [`CM_SDRAM_AW-1:0] rom_mask;
    logic [`CM_SDRAM_AW-1:0] prg_addr_d;
    logic [`CM_SDRAM_AW-1:0] chr_addr_d;
    logic                    prg_hit;

    // PRG image sits at 0 and CHR follows right after it
    assign rom_size = `CM_SDRAM_AW'(1) << prg_size;
    assign rom_mask = rom_size - 1'b1;

    always_comb begin
        case (prg_sel)
            SEL_WRAM:     prg_addr_d = `CM_WRAM_BASE + `CM_SDRAM_AW'(prg_off[12:0]);
            SEL_LAUNCHER: prg_addr_d = `CM_LAUNCHER_BASE + `CM_SDRAM_AW'(prg_off[14:0]);
            default:      prg_addr_d = `CM_SDRAM_AW'(prg_off) & rom_mask;
        endcase
    end

    assign chr_addr_d = (cur_kind == MAP_LAUNCHER)
                      ? `CM_LAUNCHER_CHR_BASE + `CM_SDRAM_AW'(chr_off)
                      : rom_size + `CM_SDRAM_AW'(chr_off);

    // Reads from any mapped region, writes only into WRAM
    assign prg_hit = (prg_sel != SEL_NONE) && (cpu_rw || (prg_sel == SEL_WRAM));

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            prg_req <= 1'b0;
            prg_we  <= 1'b0;
            chr_req <= 1'b0;
            chr_we  <= 1'b0;
        end else begin
            prg_req <= cpu_valid && prg_hit;
            prg_we  <= cpu_valid && prg_hit && !cpu_rw;
            chr_req <= ppu_valid;
            chr_we  <= ppu_valid && !ppu_rw;
        end
    end

    // Addresses hold until the next access on their bus
    always_ff @(posedge clk) begin
        if (cpu_valid) begin
            prg_addr <= prg_addr_d;
        end
        if (ppu_valid) begin
            chr_addr    <= chr_addr_d;
            ciram_a10_q <= ciram_a10;
        end
    end

endmodule

`default_nettype wire

// File: logic/cart_mapper_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_mapper_params.svh"

module cart_mapper_top (
    input  wire                      clk,
    input  wire                      cpu_reset,
    // APB slave
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire  [3:0]               paddr,
    input  wire  [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    // CPU bus, already in the clk domain
    input  wire                      cpu_valid,
    input  wire  [15:0]              cpu_addr,
    input  wire                      cpu_rw,
    input  wire  [7:0]               cpu_wdata,
    // PPU bus
    input  wire                      ppu_valid,
    input  wire  [13:0]              ppu_addr,
    input  wire                      ppu_rw,
    // SDRAM requests
    output logic                     prg_req,
    output logic                     prg_we,
    output logic [`CM_SDRAM_AW-1:0]  prg_addr,
    output logic                     chr_req,
    output logic                     chr_we,
    output logic [`CM_SDRAM_AW-1:0]  chr_addr,
    output logic                     ciram_a10
);
    import cart_mapper_pkg::*;

    mapper_kind_e             pending_kind;
    mapper_kind_e             active_kind;
    mapper_kind_e             cur_kind;
    logic [4:0]               prg_size;
    logic                     mirroring;
    logic                     load_app;
    logic                     load_menu;
    logic                     app_taken;
    logic                     menu_taken;
    logic                     bank_reset;
    logic [`CM_PRG_OFF_W-1:0] prg_off;
    prg_sel_e                 prg_sel;
    logic [`CM_CHR_OFF_W-1:0] chr_off;
    logic                     ciram_a10_d;

    mapper_cfg_regs u_cfg_regs (
        .clk          (clk),
        .cpu_reset    (cpu_reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .active_kind  (active_kind),
        .app_taken    (app_taken),
        .menu_taken   (menu_taken),
        .pending_kind (pending_kind),
        .prg_size     (prg_size),
        .mirroring    (mirroring),
        .load_app     (load_app),
        .load_menu    (load_menu)
    );

    mapper_switch u_switch (
        .clk          (clk),
        .cpu_reset    (cpu_reset),
        .cpu_valid    (cpu_valid),
        .cpu_rw       (cpu_rw),
        .cpu_addr     (cpu_addr),
        .pending_kind (pending_kind),
        .load_app     (load_app),
        .load_menu    (load_menu),
        .active_kind  (active_kind),
        .cur_kind     (cur_kind),
        .bank_reset   (bank_reset),
        .app_taken    (app_taken),
        .menu_taken   (menu_taken)
    );

    mapper_banking u_banking (
        .clk        (clk),
        .cpu_reset  (cpu_reset),
        .bank_reset (bank_reset),
        .cur_kind   (cur_kind),
        .mirroring  (mirroring),
        .cpu_valid  (cpu_valid),
        .cpu_rw     (cpu_rw),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .ppu_addr   (ppu_addr),
        .prg_off    (prg_off),
        .prg_sel    (prg_sel),
        .chr_off    (chr_off),
        .ciram_a10  (ciram_a10_d)
    );

    sdram_addr_map u_addr_map (
        .clk         (clk),
        .cpu_reset   (cpu_reset),
        .cpu_valid   (cpu_valid),
        .cpu_rw      (cpu_rw),
        .ppu_valid   (ppu_valid),
        .ppu_rw      (ppu_rw),
        .cur_kind    (cur_kind),
        .prg_size    (prg_size),
        .prg_off     (prg_off),
        .prg_sel     (prg_sel),
        .chr_off     (chr_off),
        .ciram_a10   (ciram_a10_d),
        .prg_req     (prg_req),
        .prg_we      (prg_we),
        .prg_addr    (prg_addr),
        .chr_req     (chr_req),
        .chr_we      (chr_we),
        .chr_addr    (chr_addr),
        .ciram_a10_q (ciram_a10)
    );

endmodule

`default_nettype wire

// File: verif/cart_mapper_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cart_mapper_assertions (
    input wire                                clk,
    input wire                                cpu_reset,
    input wire                                cpu_valid,
    input wire                                cpu_rw,
    input wire [15:0]                         cpu_addr,
    input wire                                app_taken,
    input wire                                menu_taken,
    input wire cart_mapper_pkg::mapper_kind_e active_kind,
    input wire                                prg_req
);

    logic cpu_mapped;

    // 6000-FFFF is served from SDRAM, lower CPU space is not
    assign cpu_mapped = cpu_addr[15] || (cpu_addr[15:13] == 3'b011);

    // Flag clears are single-cycle pulses
    app_taken_pulse: assert property (@(posedge clk) disable iff (cpu_reset)
        app_taken |=> !app_taken)
        else $error("app_taken stayed high for more than one cycle");

    menu_taken_pulse: assert property (@(posedge clk) disable iff (cpu_reset)
        menu_taken |=> !menu_taken)
        else $error("menu_taken stayed high for more than one cycle");

    // Active mapper moves only on the edge after a vector hijack
    switch_after_hijack: assert property (@(posedge clk) disable iff (cpu_reset)
        !$stable(active_kind) |-> $past(app_taken || menu_taken))
        else $error("active mapper changed without a vector hijack");

    // PRG request exactly one cycle behind the CPU strobe
    prg_req_follows: assert property (@(posedge clk) disable iff (cpu_reset)
        (cpu_valid && cpu_rw && cpu_mapped) |=> prg_req)
        else $error("prg_req missing one cycle after a mapped CPU read");

    prg_req_source: assert property (@(posedge clk) disable iff (cpu_reset)
        prg_req |-> $past(cpu_valid && cpu_mapped))
        else $error("prg_req raised without a mapped CPU strobe one cycle before");

endmodule

bind cart_mapper_top cart_mapper_assertions u_assertions (
    .clk         (clk),
    .cpu_reset   (cpu_reset),
    .cpu_valid   (cpu_valid),
    .cpu_rw      (cpu_rw),
    .cpu_addr    (cpu_addr),
    .app_taken   (app_taken),
    .menu_taken  (menu_taken),
    .active_kind (active_kind),
    .prg_req     (prg_req)
);

`default_nettype wire

// File: verif/cart_mapper_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_mapper_params.svh"

module cart_mapper_tb;
    import cart_mapper_pkg::*;

    typedef enum int {OP_APB_WR, OP_APB_RD, OP_CPU_RD, OP_CPU_WR, OP_PPU_RD} op_e;

    logic        clk = 1'b0;
    logic        cpu_reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        cpu_valid;
    logic [15:0] cpu_addr;
    logic        cpu_rw;
    logic [7:0]  cpu_wdata;
    logic        ppu_valid;
    logic [13:0] ppu_addr;
    logic        ppu_rw;
    logic        prg_req;
    logic        prg_we;
    logic [22:0] prg_addr;
    logic        chr_req;
    logic        chr_we;
    logic [22:0] chr_addr;
    logic        ciram_a10;
    logic        table_built = 1'b0;

    // Stimulus table with one entry per index
    string       row_name[$];
    op_e         row_op[$];
    logic [15:0] row_addr[$];
    logic [31:0] row_data[$];
    logic [39:0] row_exp[$];

    // Reference model of the cartridge state
    mapper_kind_e m_pending = MAP_LAUNCHER;
    mapper_kind_e m_active = MAP_LAUNCHER;
    logic [4:0]   m_size = 5'd15;
    logic         m_mirror = 1'b0;
    logic         m_app = 1'b0;
    logic         m_menu = 1'b0;
    logic [2:0]   m_prg_bank = 3'd0;
    logic [1:0]   m_chr_bank = 2'd0;

    cart_mapper_top dut_i (.*);

    always #4 clk = ~clk;

    function automatic logic [39:0] model_step(op_e op, logic [15:0] addr, logic [31:0] data);
        mapper_kind_e kind;
        logic [22:0]  a;
        logic [22:0]  mask;
        logic [31:0]  rd_val;
        logic [14:0]  coff;
        logic         err;
        logic         rd;
        logic         req;
        logic         app_hit;
        logic         menu_hit;
        kind = m_active;
        mask = (23'd1 << m_size) - 23'd1;
        err = !(addr[3:0] == 4'h0 || addr[3:0] == 4'h4 || addr[3:0] == 4'h8);
        model_step = '0;
        case (op)
            OP_APB_WR: begin
                if (addr[3:0] == 4'h0) begin
                    m_pending = mapper_kind_e'(data[1:0]);
                    m_size = data[6:2];
                    m_mirror = data[7];
                    m_app = 1'b1;
                end else if (addr[3:0] == 4'h4 && data[0]) begin
                    m_pending = MAP_LAUNCHER;
                    m_menu = 1'b1;
                end
                model_step = {6'd0, 1'b1, err, 32'd0};
            end
            OP_APB_RD: begin
                rd_val = '0;
                if (addr[3:0] == 4'h0) begin
                    rd_val = {24'd0, m_mirror, m_size, m_pending};
                end else if (addr[3:0] == 4'h4) begin
                    rd_val = {31'd0, m_menu};
                end else if (addr[3:0] == 4'h8) begin
                    rd_val = {28'd0, m_menu, m_app, m_active};
                end
                model_step = {6'd0, 1'b1, err, rd_val};
            end
            OP_CPU_RD, OP_CPU_WR: begin
                rd = (op == OP_CPU_RD);
                app_hit = rd && (addr == 16'hFFFC) && m_app;
                menu_hit = rd && (addr == 16'hFFFA) && m_menu;
                if (menu_hit) begin
                    kind = MAP_LAUNCHER;
                end else if (app_hit) begin
                    kind = m_pending;
                end
                req = 1'b0;
                a = '0;
                if (addr[15]) begin
                    req = rd;
                    if (kind == MAP_LAUNCHER) begin
                        a = `CM_LAUNCHER_BASE + addr[14:0];
                    end else if (kind == MAP_UXROM) begin
                        a = ((addr[14] ? 23'd7 : 23'(m_prg_bank)) * 23'h4000 + addr[13:0]) & mask;
                    end else begin
                        a = 23'(addr[14:0]) & mask;
                    end
                end else if (addr >= 16'h6000) begin
                    req = 1'b1;
                    a = `CM_WRAM_BASE + addr[12:0];
                end
                model_step = {15'd0, req, req && !rd, req ? a : 23'd0};
                if (!rd && addr[15] && kind == MAP_UXROM) begin
                    m_prg_bank = data[2:0];
                end
                if (!rd && addr[15] && kind == MAP_CNROM) begin
                    m_chr_bank = data[1:0];
                end
                // A new mapper starts with cleared banks
                if (kind != m_active) begin
                    m_prg_bank = '0;
                    m_chr_bank = '0;
                end
                m_active = kind;
                if (app_hit) begin
                    m_app = 1'b0;
                end
                if (menu_hit) begin
                    m_menu = 1'b0;
                end
            end
            default: begin
                coff = (m_active == MAP_CNROM) ? m_chr_bank * 15'h2000 + addr[12:0]
                                               : 15'(addr[12:0]);
                a = (m_active == MAP_LAUNCHER) ? `CM_LAUNCHER_CHR_BASE + coff
                                               : (23'd1 << m_size) + coff;
                model_step = {14'd0, 1'b0, m_mirror ? addr[10] : addr[11], 1'b1, a};
            end
        endcase
    endfunction

    task automatic add_row(input string name, input op_e op, input logic [15:0] addr,
                           input logic [31:0] data);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_exp.push_back(model_step(op, addr, data));
    endtask

    task automatic build_table();
        add_row("status_after_reset", OP_APB_RD, 16'h8, 0);
        add_row("launcher_prg_8000", OP_CPU_RD, 16'h8000, 0);
        add_row("launcher_prg_c123", OP_CPU_RD, 16'hC123, 0);
        add_row("launcher_reset_vector", OP_CPU_RD, 16'hFFFC, 0);
        add_row("launcher_chr", OP_PPU_RD, 16'h0123, 0);
        add_row("low_ram_unmapped", OP_CPU_RD, 16'h0002, 0);
        add_row("select_uxrom", OP_APB_WR, 16'h0, 32'hC6);
        add_row("mapper_readback", OP_APB_RD, 16'h0, 0);
        add_row("status_app_pending", OP_APB_RD, 16'h8, 0);
        add_row("bad_address_read", OP_APB_RD, 16'hC, 0);
        add_row("bad_address_write", OP_APB_WR, 16'hC, 32'h55);
        add_row("uxrom_reset_vector", OP_CPU_RD, 16'hFFFC, 0);
        add_row("status_uxrom", OP_APB_RD, 16'h8, 0);
        add_row("uxrom_bank_write", OP_CPU_WR, 16'h8000, 32'h3);
        add_row("uxrom_bank_read", OP_CPU_RD, 16'h8000, 0);
        add_row("uxrom_fixed_bank", OP_CPU_RD, 16'hE5A5, 0);
        add_row("wram_write", OP_CPU_WR, 16'h6010, 32'h5A);
        add_row("wram_read", OP_CPU_RD, 16'h7FF0, 0);
        add_row("uxrom_chr", OP_PPU_RD, 16'h0456, 0);
        add_row("vertical_mirror_a10", OP_PPU_RD, 16'h2400, 0);
        add_row("vertical_mirror_a11", OP_PPU_RD, 16'h2800, 0);
        // CNROM with horizontal mirroring
        add_row("select_cnrom", OP_APB_WR, 16'h0, 32'h3F);
        add_row("cnrom_reset_vector", OP_CPU_RD, 16'hFFFC, 0);
        add_row("cnrom_chr_bank_write", OP_CPU_WR, 16'h8000, 32'h2);
        add_row("cnrom_chr", OP_PPU_RD, 16'h0010, 0);
        add_row("cnrom_prg", OP_CPU_RD, 16'hA000, 0);
        add_row("horizontal_mirror_a10", OP_PPU_RD, 16'h2400, 0);
        add_row("horizontal_mirror_a11", OP_PPU_RD, 16'h2800, 0);
        // Back to the menu and into the app again
        add_row("select_uxrom_again", OP_APB_WR, 16'h0, 32'hC6);
        add_row("uxrom_reset_vector_again", OP_CPU_RD, 16'hFFFC, 0);
        add_row("uxrom_bank_5_write", OP_CPU_WR, 16'h8000, 32'h5);
        add_row("uxrom_bank_5_read", OP_CPU_RD, 16'h9000, 0);
        add_row("menu_request", OP_APB_WR, 16'h4, 32'h1);
        add_row("status_menu_pending", OP_APB_RD, 16'h8, 0);
        add_row("menu_nmi_vector", OP_CPU_RD, 16'hFFFA, 0);
        add_row("status_back_in_menu", OP_APB_RD, 16'h8, 0);
        add_row("reload_uxrom", OP_APB_WR, 16'h0, 32'hC6);
        add_row("reload_reset_vector", OP_CPU_RD, 16'hFFFC, 0);
        add_row("banks_cleared", OP_CPU_RD, 16'h8000, 0);
        for (int i = 0; i < 12; i++) begin
            add_row("random_cpu_read", OP_CPU_RD, 16'($urandom), 0);
            add_row("random_ppu_read", OP_PPU_RD, 16'($urandom) & 16'h3FFF, 0);
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] data, output logic [39:0] resp);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        resp = {6'd0, pready, pslverr, write ? 32'd0 : prdata};
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic cpu_transfer(input logic rd, input logic [15:0] addr,
                                input logic [7:0] data, output logic [39:0] resp);
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_rw    <= rd;
        cpu_addr  <= addr;
        cpu_wdata <= data;
        @(posedge clk);
        cpu_valid <= 1'b0;
        cpu_rw    <= 1'b1;
        @(negedge clk);
        resp = {15'd0, prg_req, prg_we, prg_req ? prg_addr : 23'd0};
    endtask

    task automatic ppu_transfer(input logic [13:0] addr, output logic [39:0] resp);
        @(posedge clk);
        ppu_valid <= 1'b1;
        ppu_rw    <= 1'b1;
        ppu_addr  <= addr;
        @(posedge clk);
        ppu_valid <= 1'b0;
        @(negedge clk);
        resp = {14'd0, chr_we, ciram_a10, chr_req, chr_addr};
    endtask

    task automatic compare_row(input int i, input logic [39:0] resp);
        assert (resp === row_exp[i]) else begin
            $display("Mismatch in %s: expected %h, actual %h", row_name[i], row_exp[i], resp);
            $display(">>> FAIL");
            $fatal;
        end
    endtask

    initial begin
        logic [39:0] resp;
        cpu_reset = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        cpu_rw    = 1'b1;
        cpu_wdata = '0;
        ppu_valid = 1'b0;
        ppu_addr  = '0;
        ppu_rw    = 1'b1;
        void'($urandom(94674));
        build_table();
        table_built = 1'b1;
        repeat (8) @(posedge clk);
        cpu_reset <= 1'b0;
        for (int i = 0; i < row_name.size(); i++) begin
            case (row_op[i])
                OP_APB_WR: apb_transfer(1'b1, row_addr[i][3:0], row_data[i], resp);
                OP_APB_RD: apb_transfer(1'b0, row_addr[i][3:0], row_data[i], resp);
                OP_CPU_RD: cpu_transfer(1'b1, row_addr[i], row_data[i][7:0], resp);
                OP_CPU_WR: cpu_transfer(1'b0, row_addr[i], row_data[i][7:0], resp);
                default:   ppu_transfer(row_addr[i][13:0], resp);
            endcase
            compare_row(i, resp);
        end
        $display(">>> PASS");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_built);
        repeat (row_name.size() * 20 + 8) @(posedge clk);
        $display("Timeout: the stimulus table did not complete in time");
        $display(">>> FAIL");
        $fatal;
    end

endmodule

`default_nettype wire

// File: cart_mapper.f
+incdir+logic
logic/cart_mapper_pkg.sv
logic/mapper_cfg_regs.sv
logic/mapper_switch.sv
logic/mapper_banking.sv
logic/sdram_addr_map.sv
logic/cart_mapper_top.sv
verif/cart_mapper_assertions.sv
verif/cart_mapper_tb.sv

// File: Bender.yml
package:
  name: cart_mapper

sources:
  - include_dirs:
      - logic
    files:
      - logic/cart_mapper_pkg.sv
      - logic/mapper_cfg_regs.sv
      - logic/mapper_switch.sv
      - logic/mapper_banking.sv
      - logic/sdram_addr_map.sv
      - logic/cart_mapper_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/cart_mapper_assertions.sv
      - verif/cart_mapper_tb.sv
